// File: hw/id_pkg.sv
package id_pkg;

  //////////////////////////////////////////////////
  // Widths and instruction field positions
  //////////////////////////////////////////////////

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  // LSB of each field in the 32-bit instruction word
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int FUNCT7_LSB = 25;

  //////////////////////////////////////////////////
  // Encodings
  //////////////////////////////////////////////////

  // RV32I major opcodes, only the supported ones
  typedef enum logic [6:0] {
    OPCODE_LOAD   = 7'h03,
    OPCODE_OPIMM  = 7'h13,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_STORE  = 7'h23,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JALR   = 7'h67,
    OPCODE_JAL    = 7'h6f,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  // Arithmetic ops first, then branch compares
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // Forwarding source for an rs operand
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  typedef enum logic [1:0] {
    OP_A_REG  = 2'b00,
    OP_A_PC   = 2'b01,
    OP_A_ZERO = 2'b10
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG = 1'b0,
    OP_B_IMM = 1'b1
  } op_b_sel_e;

  // PCINCR is the constant 4 for the link address
  typedef enum logic [1:0] {
    IMMB_I      = 2'b00,
    IMMB_S      = 2'b01,
    IMMB_U      = 2'b10,
    IMMB_PCINCR = 2'b11
  } imm_b_sel_e;

  typedef enum logic [1:0] {
    OP_C_REGB = 2'b00,
    OP_C_BCH  = 2'b01,
    OP_C_ZERO = 2'b10
  } op_c_sel_e;

  // Control transfer kind
  typedef enum logic [1:0] {
    XFER_NONE   = 2'b00,
    XFER_JAL    = 2'b01,
    XFER_JALR   = 2'b10,
    XFER_BRANCH = 2'b11
  } xfer_e;

  typedef enum logic [1:0] {
    LSU_BYTE = 2'b00,
    LSU_HALF = 2'b01,
    LSU_WORD = 2'b10
  } lsu_size_e;

  //////////////////////////////////////////////////
  // Stage interface structs
  //////////////////////////////////////////////////

  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  // jalr_fw_sel only ever picks REGFILE or FW_WB
  typedef struct packed {
    fw_sel_e operand_a_fw_sel;
    fw_sel_e operand_b_fw_sel;
    fw_sel_e jalr_fw_sel;
  } byp_sel_t;

  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_t;

  // Decoder output
  typedef struct packed {
    logic       alu_en;
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_b_sel_e imm_b_sel;
    op_c_sel_e  op_c_sel;
    logic [1:0] rf_re;
    logic       rf_we;
    logic       lsu_en;
    logic       lsu_we;
    lsu_size_e  lsu_size;
    logic       lsu_sign_ext;
    xfer_e      xfer;
    logic       illegal;
    logic       ecall;
    logic       ebreak;
  } decode_t;

  // ID/EX pipeline entry
  typedef struct packed {
    logic                  instr_valid;
    logic                  alu_en;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       operand_c;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic                  lsu_en;
    logic                  lsu_we;
    lsu_size_e             lsu_size;
    logic                  lsu_sign_ext;
    logic                  branch;
    logic                  jump;
    logic                  illegal;
    logic                  ecall;
    logic                  ebreak;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       instr;
  } id_ex_t;

endpackage

// File: hw/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import id_pkg::*; (
  input  logic [XLEN-1:0] instr_i,
  output decode_t         dec_o
);

  // Instruction fields
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [REG_ADDR_W-1:0] rd;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[FUNCT3_LSB +: 3];
  assign funct7 = instr_i[FUNCT7_LSB +: 7];
  assign rd     = instr_i[RD_LSB +: REG_ADDR_W];

  // Base ALU op from funct3, shared by OP and OP-IMM
  // SUB and SRA are picked by funct7 at the call site
  function automatic alu_op_e base_alu_op(input logic [2:0] f3);
    case (f3)
      3'b000:  return ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    // Defaults describe a plain register ALU op with nothing enabled
    dec_o           = '0;
    dec_o.alu_op    = ALU_ADD;
    dec_o.op_a_sel  = OP_A_REG;
    dec_o.op_b_sel  = OP_B_REG;
    dec_o.imm_b_sel = IMMB_I;
    dec_o.op_c_sel  = OP_C_ZERO;
    dec_o.lsu_size  = LSU_WORD;
    dec_o.xfer      = XFER_NONE;

    case (opcode)
      ////////////////////////////////////////////////
      // Register and immediate ALU ops
      ////////////////////////////////////////////////
      OPCODE_OP: begin
        dec_o.alu_en = 1'b1;
        dec_o.rf_re  = 2'b11;
        dec_o.rf_we  = 1'b1;
        if (funct7 == 7'b000_0000) begin
          dec_o.alu_op = base_alu_op(funct3);
        end else if (funct7 == 7'b010_0000 && funct3 == 3'b000) begin
          dec_o.alu_op = ALU_SUB;
        end else if (funct7 == 7'b010_0000 && funct3 == 3'b101) begin
          dec_o.alu_op = ALU_SRA;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      OPCODE_OPIMM: begin
        dec_o.alu_en   = 1'b1;
        dec_o.rf_re    = 2'b01;
        dec_o.rf_we    = 1'b1;
        dec_o.op_b_sel = OP_B_IMM;
        dec_o.alu_op   = base_alu_op(funct3);
        // Shift amounts need a clean upper field
        if (funct3 == 3'b001 && funct7 != 7'b000_0000) begin
          dec_o.illegal = 1'b1;
        end else if (funct3 == 3'b101) begin
          if (funct7 == 7'b010_0000) begin
            dec_o.alu_op = ALU_SRA;
          end else if (funct7 != 7'b000_0000) begin
            dec_o.illegal = 1'b1;
          end
        end
      end

      // LUI is 0 + U immediate, AUIPC is PC + U immediate
      OPCODE_LUI, OPCODE_AUIPC: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_U;
      end

      ////////////////////////////////////////////////
      // Jumps and branches
      ////////////////////////////////////////////////
      // ALU builds the link address PC + 4
      OPCODE_JAL, OPCODE_JALR: begin
        dec_o.alu_en    = 1'b1;
        dec_o.rf_we     = 1'b1;
        dec_o.op_a_sel  = OP_A_PC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_PCINCR;
        if (opcode == OPCODE_JAL) begin
          dec_o.xfer = XFER_JAL;
        end else begin
          dec_o.xfer    = XFER_JALR;
          dec_o.rf_re   = 2'b01;
          dec_o.illegal = (funct3 != 3'b000);
        end
      end

      // Compare in ALU, target rides along in operand C
      OPCODE_BRANCH: begin
        dec_o.alu_en   = 1'b1;
        dec_o.rf_re    = 2'b11;
        dec_o.op_c_sel = OP_C_BCH;
        dec_o.xfer     = XFER_BRANCH;
        case (funct3)
          3'b000:  dec_o.alu_op = ALU_EQ;
          3'b001:  dec_o.alu_op = ALU_NE;
          3'b100:  dec_o.alu_op = ALU_LT;
          3'b101:  dec_o.alu_op = ALU_GE;
          3'b110:  dec_o.alu_op = ALU_LTU;
          3'b111:  dec_o.alu_op = ALU_GEU;
          default: dec_o.illegal = 1'b1;
        endcase
      end

      ////////////////////////////////////////////////
      // Loads and stores
      ////////////////////////////////////////////////
      // Address is rs1 + I or S immediate
      OPCODE_LOAD, OPCODE_STORE: begin
        dec_o.lsu_en       = 1'b1;
        dec_o.op_b_sel     = OP_B_IMM;
        dec_o.lsu_size     = lsu_size_e'(funct3[1:0]);
        dec_o.lsu_sign_ext = !funct3[2];
        if (opcode == OPCODE_LOAD) begin
          dec_o.rf_re = 2'b01;
          dec_o.rf_we = 1'b1;
          // LW has no unsigned form, size 3 does not exist
          dec_o.illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
        end else begin
          dec_o.rf_re     = 2'b11;
          dec_o.lsu_we    = 1'b1;
          dec_o.imm_b_sel = IMMB_S;
          dec_o.op_c_sel  = OP_C_REGB;
          dec_o.illegal   = (funct3[2] || funct3[1:0] == 2'b11);
        end
      end

      // Only exact ECALL and EBREAK words
      OPCODE_SYSTEM: begin
        if (instr_i == 32'h0000_0073) begin
          dec_o.ecall = 1'b1;
        end else if (instr_i == 32'h0010_0073) begin
          dec_o.ebreak = 1'b1;
        end else begin
          dec_o.illegal = 1'b1;
        end
      end

      default: dec_o.illegal = 1'b1;
    endcase

    // x0 is never written
    if (rd == '0) begin
      dec_o.rf_we = 1'b0;
    end

    // Illegal encodings do nothing downstream
    if (dec_o.illegal) begin
      dec_o.alu_en = 1'b0;
      dec_o.rf_we  = 1'b0;
      dec_o.lsu_en = 1'b0;
      dec_o.lsu_we = 1'b0;
      dec_o.rf_re  = 2'b00;
      dec_o.xfer   = XFER_NONE;
    end
  end

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select import id_pkg::*; (
  input  if_id_t                if_id_i,
  input  decode_t               dec_i,
  input  byp_sel_t              byp_sel_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic [XLEN-1:0]       rf_wdata_ex_i,
  input  logic [XLEN-1:0]       rf_wdata_wb_i,
  output logic [XLEN-1:0]       operand_a_o,
  output logic [XLEN-1:0]       operand_b_o,
  output logic [XLEN-1:0]       operand_c_o,
  output logic [XLEN-1:0]       jmp_target_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o
);

  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  // Immediate picked for operand B
  logic [XLEN-1:0] imm_op_b;
  // Forwarded rs1, rs2 and the JALR base
  logic [XLEN-1:0] operand_a_fw;
  logic [XLEN-1:0] operand_b_fw;
  logic [XLEN-1:0] jalr_fw;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] bch_target;

  // One forwarding mux, used for both rs operands
  function automatic logic [XLEN-1:0] fw_mux(
    input fw_sel_e         sel,
    input logic [XLEN-1:0] rf_data,
    input logic [XLEN-1:0] ex_data,
    input logic [XLEN-1:0] wb_data
  );
    case (sel)
      SEL_FW_EX: return ex_data;
      SEL_FW_WB: return wb_data;
      default:   return rf_data;
    endcase
  endfunction

  assign instr = if_id_i.instr;

  // Register file read addresses, straight from the word
  assign rf_raddr_a_o = instr[RS1_LSB +: REG_ADDR_W];
  assign rf_raddr_b_o = instr[RS2_LSB +: REG_ADDR_W];

  //////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  //////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////

  assign operand_a_fw = fw_mux(byp_sel_i.operand_a_fw_sel, rf_rdata_a_i,
                               rf_wdata_ex_i, rf_wdata_wb_i);
  assign operand_b_fw = fw_mux(byp_sel_i.operand_b_fw_sel, rf_rdata_b_i,
                               rf_wdata_ex_i, rf_wdata_wb_i);

  // JALR base has no EX path
  assign jalr_fw = (byp_sel_i.jalr_fw_sel == SEL_FW_WB) ? rf_wdata_wb_i : rf_rdata_a_i;

  //////////////////////////////////////////////////
  // Operand muxes
  //////////////////////////////////////////////////

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_PC:   operand_a_o = if_id_i.pc;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = operand_a_fw;
    endcase
  end

  always_comb begin
    case (dec_i.imm_b_sel)
      IMMB_S:      imm_op_b = imm_s;
      IMMB_U:      imm_op_b = imm_u;
      IMMB_PCINCR: imm_op_b = 32'd4;
      default:     imm_op_b = imm_i;
    endcase
  end

  assign operand_b_o = (dec_i.op_b_sel == OP_B_IMM) ? imm_op_b : operand_b_fw;

  // Store data or branch target for EX
  always_comb begin
    case (dec_i.op_c_sel)
      OP_C_REGB: operand_c_o = operand_b_fw;
      OP_C_BCH:  operand_c_o = bch_target;
      default:   operand_c_o = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Jump and branch targets
  //////////////////////////////////////////////////

  assign bch_target = if_id_i.pc + imm_b;
  assign jalr_sum   = jalr_fw + imm_i;

  // JALR drops bit 0, everything else uses the JAL form
  assign jmp_target_o = (dec_i.xfer == XFER_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                  : if_id_i.pc + imm_j;

endmodule

// File: hw/id_ex_register.sv
`timescale 1ns/1ps

module id_ex_register import id_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid_i,
  input  ctrl_t           ctrl_i,
  input  logic            ex_ready_i,
  input  decode_t         dec_i,
  input  logic [XLEN-1:0] pc_i,
  input  logic [XLEN-1:0] instr_i,
  input  logic [XLEN-1:0] operand_a_i,
  input  logic [XLEN-1:0] operand_b_i,
  input  logic [XLEN-1:0] operand_c_i,
  output logic            id_ready_o,
  output logic            id_valid_o,
  output id_ex_t          id_ex_pipe_o
);

  // Stage handshake
  // Halt and kill both hide the instruction from EX
  assign id_valid_o = instr_valid_i && !ctrl_i.kill_id && !ctrl_i.halt_id;
  // Kill drains ID regardless of EX
  assign id_ready_o = ctrl_i.kill_id || (ex_ready_i && !ctrl_i.halt_id);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // All clear, alu_op parks on SLTU
      id_ex_pipe_o        <= '0;
      id_ex_pipe_o.alu_op <= ALU_SLTU;
    end else if (id_valid_o && ex_ready_i) begin
      id_ex_pipe_o.instr_valid <= 1'b1;
      id_ex_pipe_o.alu_en      <= dec_i.alu_en;

      // Operands only move when something consumes them
      if (dec_i.alu_en || dec_i.lsu_en) begin
        id_ex_pipe_o.alu_op    <= dec_i.alu_op;
        id_ex_pipe_o.operand_a <= operand_a_i;
        id_ex_pipe_o.operand_b <= operand_b_i;
        id_ex_pipe_o.operand_c <= operand_c_i;
      end

      id_ex_pipe_o.rf_we    <= dec_i.rf_we;
      id_ex_pipe_o.rf_waddr <= instr_i[RD_LSB +: REG_ADDR_W];

      id_ex_pipe_o.lsu_en <= dec_i.lsu_en;
      if (dec_i.lsu_en) begin
        id_ex_pipe_o.lsu_we       <= dec_i.lsu_we;
        id_ex_pipe_o.lsu_size     <= dec_i.lsu_size;
        id_ex_pipe_o.lsu_sign_ext <= dec_i.lsu_sign_ext;
      end

      id_ex_pipe_o.branch <= (dec_i.xfer == XFER_BRANCH);
      id_ex_pipe_o.jump   <= (dec_i.xfer == XFER_JAL) || (dec_i.xfer == XFER_JALR);

      // Exception info for WB
      id_ex_pipe_o.illegal <= dec_i.illegal;
      id_ex_pipe_o.ecall   <= dec_i.ecall;
      id_ex_pipe_o.ebreak  <= dec_i.ebreak;
      id_ex_pipe_o.pc      <= pc_i;
      id_ex_pipe_o.instr   <= instr_i;
    end else if (ex_ready_i) begin
      // EX took the old entry, nothing new, so bubble
      id_ex_pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

// File: hw/id_stage.sv
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  if_id_t                if_id_i,
  input  byp_sel_t              byp_sel_i,
  input  ctrl_t                 ctrl_i,
  input  logic                  ex_ready_i,
  input  logic [XLEN-1:0]       rf_rdata_a_i,
  input  logic [XLEN-1:0]       rf_rdata_b_i,
  input  logic [XLEN-1:0]       rf_wdata_ex_i,
  input  logic [XLEN-1:0]       rf_wdata_wb_i,
  output logic [REG_ADDR_W-1:0] rf_raddr_a_o,
  output logic [REG_ADDR_W-1:0] rf_raddr_b_o,
  output logic [1:0]            rf_re_o,
  output logic [XLEN-1:0]       jmp_target_o,
  output logic                  id_ready_o,
  output logic                  id_valid_o,
  output id_ex_t                id_ex_pipe_o
);

  decode_t         dec;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic [XLEN-1:0] operand_c;

  // Read enables go straight to the register file
  assign rf_re_o = dec.rf_re;

  instr_decoder decoder_i (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  // Immediates, forwarding and targets
  operand_select operand_select_i (
    .if_id_i       (if_id_i),
    .dec_i         (dec),
    .byp_sel_i     (byp_sel_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .operand_c_o   (operand_c),
    .jmp_target_o  (jmp_target_o),
    .rf_raddr_a_o  (rf_raddr_a_o),
    .rf_raddr_b_o  (rf_raddr_b_o)
  );

  id_ex_register id_ex_register_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (if_id_i.instr_valid),
    .ctrl_i        (ctrl_i),
    .ex_ready_i    (ex_ready_i),
    .dec_i         (dec),
    .pc_i          (if_id_i.pc),
    .instr_i       (if_id_i.instr),
    .operand_a_i   (operand_a),
    .operand_b_i   (operand_b),
    .operand_c_i   (operand_c),
    .id_ready_o    (id_ready_o),
    .id_valid_o    (id_valid_o),
    .id_ex_pipe_o  (id_ex_pipe_o)
  );

endmodule

// File: test/id_stage_props.sv
`timescale 1ns/1ps

module id_stage_props import id_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input ctrl_t  ctrl_i,
  input logic   ex_ready_i,
  input logic   id_valid_i,
  input id_ex_t id_ex_pipe_i
);

  // Halt or kill hide the instruction from EX
  valid_blocked_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    (ctrl_i.halt_id || ctrl_i.kill_id) |-> !id_valid_i
  ) else $error("id_valid_o high while halt or kill is set");

  // Back-pressure freezes the whole entry
  hold_on_stall_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    !ex_ready_i |=> $stable(id_ex_pipe_i)
  ) else $error("ID/EX entry changed while ex_ready_i was low");

  // First cycle out of reset sees the reset entry
  reset_entry_a: assert property (
    @(posedge clk)
    $rose(rst_n) |-> (!id_ex_pipe_i.instr_valid && id_ex_pipe_i.alu_op == ALU_SLTU)
  ) else $error("ID/EX entry not in reset state after reset release");

endmodule

bind id_stage id_stage_props props_i (
  .clk          (clk),
  .rst_n        (rst_n),
  .ctrl_i       (ctrl_i),
  .ex_ready_i   (ex_ready_i),
  .id_valid_i   (id_valid_o),
  .id_ex_pipe_i (id_ex_pipe_o)
);

// File: test/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

  localparam int N_TRANS        = 400;
  localparam int ACCEPT_TIMEOUT = 60;
  localparam int MIN_TRANSFERS  = N_TRANS / 2;

  logic                  clk;
  logic                  rst_n;
  if_id_t                if_id;
  byp_sel_t              byp_sel;
  ctrl_t                 ctrl;
  logic                  ex_ready;
  logic [XLEN-1:0]       rf_rdata_a;
  logic [XLEN-1:0]       rf_rdata_b;
  logic [XLEN-1:0]       rf_wdata_ex;
  logic [XLEN-1:0]       rf_wdata_wb;
  logic [REG_ADDR_W-1:0] rf_raddr_a;
  logic [REG_ADDR_W-1:0] rf_raddr_b;
  logic [1:0]            rf_re;
  logic [XLEN-1:0]       jmp_target;
  logic                  id_ready;
  logic                  id_valid;
  id_ex_t                id_ex_pipe;

  // Expected state of the ID/EX register
  id_ex_t          exp_entry;
  // Entry that the next transfer edge should load
  id_ex_t          next_entry;
  logic [XLEN-1:0] next_jt;
  // Register file read enables for the word at the input
  logic [1:0]      next_re;
  logic            exp_valid;
  logic            exp_ready;
  logic [31:0]     lfsr_state;
  logic [XLEN-1:0] cur_pc;
  int              n_transfers;

  id_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id),
    .byp_sel_i     (byp_sel),
    .ctrl_i        (ctrl),
    .ex_ready_i    (ex_ready),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_re_o       (rf_re),
    .jmp_target_o  (jmp_target),
    .id_ready_o    (id_ready),
    .id_valid_o    (id_valid),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Handshake as the stage should see it
  assign exp_valid = if_id.instr_valid && !ctrl.halt_id && !ctrl.kill_id;
  assign exp_ready = ctrl.kill_id || (ex_ready && !ctrl.halt_id);

  //////////////////////////////////////////////////
  // Random source
  //////////////////////////////////////////////////

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Random word, then opcode and key fields forced per class
  function automatic logic [31:0] gen_instr();
    logic [31:0] w;
    logic [3:0]  cls;
    w   = rand_bits(32);
    cls = 4'(rand_bits(4));
    case (cls)
      4'd0, 4'd1, 4'd2: begin
        w[6:0]   = OPCODE_OP;
        w[31:25] = (rand_bits(2) == 0) ? 7'h20 : 7'h00;
      end
      4'd3, 4'd4: begin
        w[6:0] = OPCODE_OPIMM;
        // Shifts get a mostly clean upper field
        if (w[13:12] == 2'b01) begin
          w[31:25] = rand_bits(1) ? 7'h20 : 7'h00;
        end
      end
      4'd5:  w[6:0] = rand_bits(1) ? OPCODE_LUI : OPCODE_AUIPC;
      4'd6:  w[6:0] = OPCODE_JAL;
      4'd7: begin
        w[6:0] = OPCODE_JALR;
        if (rand_bits(2) != 0) begin
          w[14:12] = 3'b000;
        end
      end
      4'd8, 4'd9:   w[6:0] = OPCODE_BRANCH;
      4'd10, 4'd11: w[6:0] = OPCODE_LOAD;
      4'd12:        w[6:0] = OPCODE_STORE;
      4'd13:        w = rand_bits(1) ? 32'h0000_0073 : 32'h0010_0073;
      default:      w = rand_bits(32);
    endcase
    // Some x0 destinations
    if (rand_bits(3) == 0) begin
      w[11:7] = 5'd0;
    end
    return w;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic alu_op_e funct3_alu_op(input logic [2:0] f3);
    case (f3)
      3'd0:    return ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // Entry loaded on a transfer, fields not loaded keep prev
  function automatic id_ex_t ref_entry(
    input  if_id_t          f,
    input  byp_sel_t        b,
    input  logic [XLEN-1:0] ra,
    input  logic [XLEN-1:0] rb,
    input  logic [XLEN-1:0] ex,
    input  logic [XLEN-1:0] wb,
    input  id_ex_t          prev,
    output logic [XLEN-1:0] jt,
    output logic [1:0]      re
  );
    logic [31:0] w;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] fa;
    logic [31:0] fb;
    logic [31:0] jsum;
    logic [31:0] oa;
    logic [31:0] ob;
    logic [31:0] oc;
    alu_op_e     op;
    lsu_size_e   size;
    logic        lsu_we;
    logic        sgn;
    id_ex_t      e;
    w     = f.instr;
    opc   = w[6:0];
    f3    = w[14:12];
    f7    = w[31:25];
    imm_i = 32'($signed(w[31:20]));
    imm_s = 32'($signed({w[31:25], w[11:7]}));
    imm_b = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
    imm_u = {w[31:12], 12'h000};
    imm_j = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
    fa    = (b.operand_a_fw_sel == SEL_FW_EX) ? ex :
            (b.operand_a_fw_sel == SEL_FW_WB) ? wb : ra;
    fb    = (b.operand_b_fw_sel == SEL_FW_EX) ? ex :
            (b.operand_b_fw_sel == SEL_FW_WB) ? wb : rb;
    jsum  = ((b.jalr_fw_sel == SEL_FW_WB) ? wb : ra) + imm_i;

    e             = prev;
    e.instr_valid = 1'b1;
    e.pc          = f.pc;
    e.instr       = w;
    e.rf_waddr    = w[11:7];
    e.alu_en      = 1'b0;
    e.rf_we       = 1'b0;
    e.lsu_en      = 1'b0;
    e.branch      = 1'b0;
    e.jump        = 1'b0;
    e.illegal     = 1'b0;
    e.ecall       = 1'b0;
    e.ebreak      = 1'b0;
    op     = ALU_ADD;
    oa     = fa;
    ob     = fb;
    oc     = '0;
    lsu_we = 1'b0;
    size   = LSU_WORD;
    sgn    = 1'b0;
    re     = 2'b00;

    case (opc)
      OPCODE_OP: begin
        e.alu_en = 1'b1;
        e.rf_we  = 1'b1;
        re       = 2'b11;
        if (f7 == 7'h00) op = funct3_alu_op(f3);
        else if (f7 == 7'h20 && f3 == 3'd0) op = ALU_SUB;
        else if (f7 == 7'h20 && f3 == 3'd5) op = ALU_SRA;
        else e.illegal = 1'b1;
      end
      OPCODE_OPIMM: begin
        e.alu_en = 1'b1;
        e.rf_we  = 1'b1;
        re       = 2'b01;
        ob       = imm_i;
        op       = funct3_alu_op(f3);
        if (f3 == 3'd1 && f7 != 7'h00) e.illegal = 1'b1;
        else if (f3 == 3'd5 && f7 == 7'h20) op = ALU_SRA;
        else if (f3 == 3'd5 && f7 != 7'h00) e.illegal = 1'b1;
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        e.alu_en = 1'b1;
        e.rf_we  = 1'b1;
        oa       = (opc == OPCODE_LUI) ? '0 : f.pc;
        ob       = imm_u;
      end
      // Link address is PC + 4
      OPCODE_JAL, OPCODE_JALR: begin
        e.alu_en  = 1'b1;
        e.rf_we   = 1'b1;
        e.jump    = 1'b1;
        oa        = f.pc;
        ob        = 32'd4;
        re        = (opc == OPCODE_JALR) ? 2'b01 : 2'b00;
        e.illegal = (opc == OPCODE_JALR) && (f3 != 3'd0);
      end
      OPCODE_BRANCH: begin
        e.alu_en = 1'b1;
        e.branch = 1'b1;
        re       = 2'b11;
        oc       = f.pc + imm_b;
        case (f3)
          3'd0:    op = ALU_EQ;
          3'd1:    op = ALU_NE;
          3'd4:    op = ALU_LT;
          3'd5:    op = ALU_GE;
          3'd6:    op = ALU_LTU;
          3'd7:    op = ALU_GEU;
          default: e.illegal = 1'b1;
        endcase
      end
      OPCODE_LOAD: begin
        e.lsu_en  = 1'b1;
        e.rf_we   = 1'b1;
        re        = 2'b01;
        ob        = imm_i;
        size      = lsu_size_e'(f3[1:0]);
        sgn       = !f3[2];
        e.illegal = (f3[1:0] == 2'b11) || (f3 == 3'd6);
      end
      OPCODE_STORE: begin
        e.lsu_en  = 1'b1;
        lsu_we    = 1'b1;
        re        = 2'b11;
        ob        = imm_s;
        oc        = fb;
        size      = lsu_size_e'(f3[1:0]);
        sgn       = !f3[2];
        e.illegal = f3[2] || (f3[1:0] == 2'b11);
      end
      OPCODE_SYSTEM: begin
        if (w == 32'h0000_0073) e.ecall = 1'b1;
        else if (w == 32'h0010_0073) e.ebreak = 1'b1;
        else e.illegal = 1'b1;
      end
      default: e.illegal = 1'b1;
    endcase

    if (w[11:7] == 5'd0) e.rf_we = 1'b0;
    if (e.illegal) begin
      e.alu_en = 1'b0;
      e.rf_we  = 1'b0;
      e.lsu_en = 1'b0;
      e.branch = 1'b0;
      e.jump   = 1'b0;
      re       = 2'b00;
    end
    // Operands and LSU fields only load when used
    if (e.alu_en || e.lsu_en) begin
      e.alu_op    = op;
      e.operand_a = oa;
      e.operand_b = ob;
      e.operand_c = oc;
    end
    if (e.lsu_en) begin
      e.lsu_we       = lsu_we;
      e.lsu_size     = size;
      e.lsu_sign_ext = sgn;
    end
    jt = (opc == OPCODE_JALR && f3 == 3'd0 && !e.illegal) ? {jsum[31:1], 1'b0}
                                                           : f.pc + imm_j;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // Checking
  //////////////////////////////////////////////////

  task automatic stop_on_failure(input string line);
    $display("%s", line);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  // Model register follows the same edges as the DUT
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_entry        <= '0;
      exp_entry.alu_op <= ALU_SLTU;
    end else if (exp_valid && ex_ready) begin
      exp_entry   <= next_entry;
      n_transfers <= n_transfers + 1;
    end else if (ex_ready) begin
      exp_entry.instr_valid <= 1'b0;
    end
  end

  // Compare mid cycle, inputs and outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      next_entry = ref_entry(if_id, byp_sel, rf_rdata_a, rf_rdata_b,
                             rf_wdata_ex, rf_wdata_wb, exp_entry, next_jt, next_re);
      assert (id_ex_pipe === exp_entry) else
        stop_on_failure($sformatf("ERR @%0t: ID/EX entry %h, expected %h",
                                  $time, id_ex_pipe, exp_entry));
      assert (id_valid === exp_valid && id_ready === exp_ready) else
        stop_on_failure($sformatf("ERR @%0t: valid/ready %b%b, expected %b%b",
                                  $time, id_valid, id_ready, exp_valid, exp_ready));
      assert (jmp_target === next_jt) else
        stop_on_failure($sformatf("ERR @%0t: jump target %h, expected %h",
                                  $time, jmp_target, next_jt));
      assert (rf_re === next_re) else
        stop_on_failure($sformatf("ERR @%0t: read enables %b, expected %b",
                                  $time, rf_re, next_re));
      assert (rf_raddr_a === if_id.instr[19:15] && rf_raddr_b === if_id.instr[24:20]) else
        stop_on_failure($sformatf("ERR @%0t: read addresses %0d %0d", $time,
                                  rf_raddr_a, rf_raddr_b));
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Controller, register file and bypass side, new each cycle
  task automatic drive_side();
    logic [1:0] r;
    r = 2'(rand_bits(2));
    byp_sel.operand_a_fw_sel <= (r == 2'b11) ? SEL_REGFILE : fw_sel_e'(r);
    r = 2'(rand_bits(2));
    byp_sel.operand_b_fw_sel <= (r == 2'b11) ? SEL_REGFILE : fw_sel_e'(r);
    byp_sel.jalr_fw_sel      <= rand_bits(1) ? SEL_FW_WB : SEL_REGFILE;
    rf_rdata_a  <= rand_bits(32);
    rf_rdata_b  <= rand_bits(32);
    rf_wdata_ex <= rand_bits(32);
    rf_wdata_wb <= rand_bits(32);
    ex_ready     <= (rand_bits(3) != 0);
    ctrl.halt_id <= (rand_bits(3) == 0);
    ctrl.kill_id <= (rand_bits(4) == 0);
  endtask

  initial begin
    int waited;
    rst_n       = 1'b0;
    if_id       = '0;
    byp_sel     = '0;
    ctrl        = '0;
    ex_ready    = 1'b0;
    rf_rdata_a  = '0;
    rf_rdata_b  = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    n_transfers = 0;
    lfsr_state  = 32'd42;
    cur_pc      = 32'h0000_1000;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    for (int t = 0; t < N_TRANS; t++) begin
      // Occasional fetch bubble
      if (rand_bits(3) == 0) begin
        if_id.instr_valid <= 1'b0;
        drive_side();
        @(posedge clk);
      end
      if_id <= {1'b1, cur_pc, gen_instr()};
      drive_side();
      cur_pc = cur_pc + 32'd4;
      waited = 0;
      @(posedge clk);
      // Hold the word until the stage takes it
      while (!(id_ready && if_id.instr_valid)) begin
        drive_side();
        waited++;
        if (waited > ACCEPT_TIMEOUT) begin
          stop_on_failure($sformatf("timeout: instruction at pc %h not accepted in %0d cycles",
                                    if_id.pc, ACCEPT_TIMEOUT));
        end
        @(posedge clk);
      end
    end

    // Drain the last entry
    if_id.instr_valid <= 1'b0;
    ctrl              <= '0;
    ex_ready          <= 1'b1;
    repeat (3) @(posedge clk);

    if (n_transfers >= MIN_TRANSFERS) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_on_failure($sformatf("only %0d instructions reached EX", n_transfers));
    end
  end

endmodule

// File: vlog.f
hw/id_pkg.sv
hw/instr_decoder.sv
hw/operand_select.sv
hw/id_ex_register.sv
hw/id_stage.sv
test/id_stage_props.sv
test/id_stage_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the ID stage testbench with Verilator
verilator --binary --timing --assert -Mdir obj_dir --top-module id_stage_tb -f vlog.f \
  && ./obj_dir/Vid_stage_tb 2>&1 | tee sim.log \
  || { echo "build or run error"; exit 1; }
grep -q "CHECKS FAILED" sim.log && { echo "FAIL"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "FAIL: run ended early"; exit 1; }
echo "PASS"
